//--- logic/mem_consts.svh
// Memory complex constants
// Bus widths, memory depth, host register map and loader opcodes

`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

`define MEM_ADDR_W 16
`define MEM_DATA_W 32
`define MEM_DEPTH 1024
`define MEM_WORD_W 10

// Host block in device space
`define HOST_DID 7'h7f
`define HOST_REG_FINISH 2'd0
`define HOST_REG_TRACE 2'd1
`define TRACE_W 8

// Loader command opcodes
`define NBF_OP_W 2
`define NBF_OP_WRITE 2'd1
`define NBF_OP_FINISH 2'd2

`endif

//--- logic/mem_pkg.sv
// Memory complex types
// One bus address word, seen either as a DRAM word index or as a
// device register access, selected by the top bit

`include "mem_consts.svh"

package mem_pkg;

  typedef struct packed {
    logic                                 space;
    logic [`MEM_ADDR_W-1-`MEM_WORD_W-1:0] unused;
    logic [`MEM_WORD_W-1:0]               word;
  } dram_addr_s;

  // Device space, space bit set
  typedef struct packed {
    logic       space;
    logic [6:0] did;
    logic [5:0] rsvd;
    logic [1:0] reg_idx;
  } dev_addr_s;

  typedef union packed {
    dram_addr_s dram;
    dev_addr_s  dev;
  } mem_addr_u;

endpackage

//--- logic/mem_bus_if.sv
// Memory bus
// Valid/ready request channel with a response pulse that has no ready,
// one transaction outstanding per requester

`timescale 1ns/1ps
`include "mem_consts.svh"

interface mem_bus_if
  import mem_pkg::*;
();

  logic                   req_v;
  logic                   req_we;
  mem_addr_u              req_addr;
  logic [`MEM_DATA_W-1:0] req_wdata;
  logic                   req_ready;
  logic                   rsp_v;
  logic [`MEM_DATA_W-1:0] rsp_rdata;

  modport requester (
    output req_v,
    output req_we,
    output req_addr,
    output req_wdata,
    input  req_ready,
    input  rsp_v,
    input  rsp_rdata
  );

  modport responder (
    input  req_v,
    input  req_we,
    input  req_addr,
    input  req_wdata,
    output req_ready,
    output rsp_v,
    output rsp_rdata
  );

endinterface

//--- logic/mem_arbiter.sv
// Memory complex arbiter
// Round-robin between the loader and the core port, holding the bus
// until the target responds, and routing by the address space bit

`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_arbiter
  import mem_pkg::*;
(
  input  logic         clk_i,
  input  logic         arst_n_i,
  mem_bus_if.responder ldr_i,
  mem_bus_if.responder core_i,
  mem_bus_if.requester dram_o,
  mem_bus_if.requester host_o
);

  logic                   live_r;
  logic                   busy_r;
  // Owner of the bus, also the last grant (1 = core)
  logic                   owner_r;
  logic                   offer_ldr;
  logic                   offer_core;
  logic                   grant_ldr;
  logic                   grant_core;
  logic                   xfer_ldr;
  logic                   xfer_core;
  mem_addr_u              sel_addr;
  logic                   sel_we;
  logic [`MEM_DATA_W-1:0] sel_wdata;
  logic                   rsp_v;
  logic [`MEM_DATA_W-1:0] rsp_rdata;

  // Offer the bus when idle, the loser of the last round wins a tie
  assign offer_ldr  = live_r & ~busy_r & (~core_i.req_v | owner_r);
  assign offer_core = live_r & ~busy_r & (~ldr_i.req_v | ~owner_r);
  assign grant_ldr  = offer_ldr & ldr_i.req_v;
  assign grant_core = offer_core & core_i.req_v;

  assign sel_addr  = grant_core ? core_i.req_addr : ldr_i.req_addr;
  assign sel_we    = grant_core ? core_i.req_we : ldr_i.req_we;
  assign sel_wdata = grant_core ? core_i.req_wdata : ldr_i.req_wdata;

  assign dram_o.req_v     = (grant_ldr | grant_core) & ~sel_addr.dram.space;
  assign dram_o.req_we    = sel_we;
  assign dram_o.req_addr  = sel_addr;
  assign dram_o.req_wdata = sel_wdata;
  assign host_o.req_v     = (grant_ldr | grant_core) & sel_addr.dram.space;
  assign host_o.req_we    = sel_we;
  assign host_o.req_addr  = sel_addr;
  assign host_o.req_wdata = sel_wdata;

  // Ready comes back from the target that the requester addresses
  assign ldr_i.req_ready = offer_ldr &
    (ldr_i.req_addr.dram.space ? host_o.req_ready : dram_o.req_ready);
  assign core_i.req_ready = offer_core &
    (core_i.req_addr.dram.space ? host_o.req_ready : dram_o.req_ready);

  assign xfer_ldr  = ldr_i.req_v & ldr_i.req_ready;
  assign xfer_core = core_i.req_v & core_i.req_ready;

  assign rsp_v     = dram_o.rsp_v | host_o.rsp_v;
  assign rsp_rdata = host_o.rsp_v ? host_o.rsp_rdata : dram_o.rsp_rdata;

  assign ldr_i.rsp_v      = rsp_v & ~owner_r;
  assign ldr_i.rsp_rdata  = rsp_rdata;
  assign core_i.rsp_v     = rsp_v & owner_r;
  assign core_i.rsp_rdata = rsp_rdata;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      live_r  <= 1'b0;
      busy_r  <= 1'b0;
      owner_r <= 1'b0;
    end
    else
    begin
      live_r <= 1'b1;
      if (xfer_ldr | xfer_core)
      begin
        busy_r  <= 1'b1;
        owner_r <= xfer_core;
      end
      else if (rsp_v)
        busy_r <= 1'b0;
    end
  end

  a_single_xfer: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(xfer_ldr && xfer_core));

  a_rsp_when_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_v |-> busy_r);

endmodule

//--- logic/dram_model.sv
// DRAM model
// Word memory behind the bus, always ready, answering each request
// one cycle later; cleared to zero by reset

`timescale 1ns/1ps
`include "mem_consts.svh"

module dram_model
  import mem_pkg::*;
(
  input  logic         clk_i,
  input  logic         arst_n_i,
  mem_bus_if.responder bus_i
);

  logic [`MEM_DATA_W-1:0] mem [`MEM_DEPTH];
  dram_addr_s             dram_a;
  logic                   xfer;
  logic                   rsp_v_r;
  logic [`MEM_DATA_W-1:0] rdata_r;

  assign dram_a          = bus_i.req_addr.dram;
  assign bus_i.req_ready = 1'b1;
  assign xfer            = bus_i.req_v & bus_i.req_ready;

  assign bus_i.rsp_v     = rsp_v_r;
  assign bus_i.rsp_rdata = rdata_r;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rsp_v_r <= 1'b0;
      for (int i = 0; i < `MEM_DEPTH; i++)
        mem[i] <= '0;
    end
    else
    begin
      rsp_v_r <= xfer;
      if (xfer && bus_i.req_we)
        mem[dram_a.word] <= bus_i.req_wdata;
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i)
  begin
    if (xfer)
      rdata_r <= bus_i.req_we ? '0 : mem[dram_a.word];
  end

  // Only DRAM-space addresses with clean upper bits get routed here
  a_dram_addr: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    xfer |-> (!dram_a.space && dram_a.unused == '0));

endmodule

//--- logic/host_regs.sv
// Host register block
// Device-space registers for the sticky finish flag and the trace
// enable vector, both readable over the bus

`timescale 1ns/1ps
`include "mem_consts.svh"

module host_regs
  import mem_pkg::*;
(
  input  logic                clk_i,
  input  logic                arst_n_i,
  mem_bus_if.responder        bus_i,
  output logic                finish_o,
  output logic [`TRACE_W-1:0] trace_en_o
);

  dev_addr_s              dev_a;
  logic                   xfer;
  logic                   hit;
  logic [`MEM_DATA_W-1:0] rd_val;
  logic                   rsp_v_r;
  logic [`MEM_DATA_W-1:0] rdata_r;

  assign dev_a           = bus_i.req_addr.dev;
  assign bus_i.req_ready = 1'b1;
  assign xfer            = bus_i.req_v & bus_i.req_ready;
  assign hit             = dev_a.did == `HOST_DID;

  assign bus_i.rsp_v     = rsp_v_r;
  assign bus_i.rsp_rdata = rdata_r;

  // Zero for writes, foreign devices and unmapped registers
  always_comb
  begin
    rd_val = '0;
    if (hit && !bus_i.req_we)
    begin
      case (dev_a.reg_idx)
        `HOST_REG_FINISH: rd_val[0] = finish_o;
        `HOST_REG_TRACE:  rd_val[`TRACE_W-1:0] = trace_en_o;
        default:          rd_val = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rsp_v_r    <= 1'b0;
      finish_o   <= 1'b0;
      trace_en_o <= '0;
    end
    else
    begin
      rsp_v_r <= xfer;
      if (xfer && hit && bus_i.req_we && dev_a.reg_idx == `HOST_REG_FINISH)
        finish_o <= 1'b1;
      if (xfer && hit && bus_i.req_we && dev_a.reg_idx == `HOST_REG_TRACE)
        trace_en_o <= bus_i.req_wdata[`TRACE_W-1:0];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (xfer)
      rdata_r <= rd_val;
  end

endmodule

//--- logic/nbf_loader.sv
// NBF program loader
// Takes one command at a time, turns writes into bus writes and
// raises a sticky done flag on the finish command

`timescale 1ns/1ps
`include "mem_consts.svh"

module nbf_loader
  import mem_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   nbf_v_i,
  input  logic [`NBF_OP_W-1:0]   nbf_op_i,
  input  logic [`MEM_ADDR_W-1:0] nbf_addr_i,
  input  logic [`MEM_DATA_W-1:0] nbf_data_i,
  output logic                   nbf_ready_o,
  output logic                   done_o,
  mem_bus_if.requester           bus_o
);

  localparam logic [2:0] ST_BOOT = 3'd0;
  localparam logic [2:0] ST_IDLE = 3'd1;
  localparam logic [2:0] ST_REQ  = 3'd2;
  localparam logic [2:0] ST_WAIT = 3'd3;
  localparam logic [2:0] ST_DONE = 3'd4;

  logic [2:0]             state_r;
  logic                   accept;
  mem_addr_u              addr_r;
  logic [`MEM_DATA_W-1:0] data_r;

  assign nbf_ready_o = state_r == ST_IDLE;
  assign done_o      = state_r == ST_DONE;
  assign accept      = nbf_v_i & nbf_ready_o;

  assign bus_o.req_v     = state_r == ST_REQ;
  assign bus_o.req_we    = 1'b1;
  assign bus_o.req_addr  = addr_r;
  assign bus_o.req_wdata = data_r;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      state_r <= ST_BOOT;
    else
    begin
      case (state_r)
        ST_BOOT: state_r <= ST_IDLE;
        ST_IDLE:
        begin
          // Unknown opcodes are taken and dropped
          if (accept && nbf_op_i == `NBF_OP_WRITE)
            state_r <= ST_REQ;
          else if (accept && nbf_op_i == `NBF_OP_FINISH)
            state_r <= ST_DONE;
        end
        ST_REQ:  if (bus_o.req_ready) state_r <= ST_WAIT;
        ST_WAIT: if (bus_o.rsp_v) state_r <= ST_IDLE;
        ST_DONE: state_r <= ST_DONE;
        default: state_r <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      addr_r <= nbf_addr_i;
      data_r <= nbf_data_i;
    end
  end

  a_done_sticky: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    done_o |=> done_o);

endmodule

//--- logic/mem_complex_top.sv
// Memory complex top
// Loader and core port share the DRAM model and the host registers
// through the round-robin arbiter

`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_complex_top
(
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   nbf_v_i,
  input  logic [`NBF_OP_W-1:0]   nbf_op_i,
  input  logic [`MEM_ADDR_W-1:0] nbf_addr_i,
  input  logic [`MEM_DATA_W-1:0] nbf_data_i,
  output logic                   nbf_ready_o,
  output logic                   done_o,
  input  logic                   core_v_i,
  input  logic                   core_we_i,
  input  logic [`MEM_ADDR_W-1:0] core_addr_i,
  input  logic [`MEM_DATA_W-1:0] core_wdata_i,
  output logic                   core_ready_o,
  output logic                   core_rsp_v_o,
  output logic [`MEM_DATA_W-1:0] core_rsp_data_o,
  output logic                   finish_o,
  output logic [`TRACE_W-1:0]    trace_en_o
);

  mem_bus_if ldr_bus ();
  mem_bus_if core_bus ();
  mem_bus_if dram_bus ();
  mem_bus_if host_bus ();

  // Core port onto its bus
  assign core_bus.req_v     = core_v_i;
  assign core_bus.req_we    = core_we_i;
  assign core_bus.req_addr  = core_addr_i;
  assign core_bus.req_wdata = core_wdata_i;
  assign core_ready_o       = core_bus.req_ready;
  assign core_rsp_v_o       = core_bus.rsp_v;
  assign core_rsp_data_o    = core_bus.rsp_rdata;

  nbf_loader u_loader (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .nbf_v_i     (nbf_v_i),
    .nbf_op_i    (nbf_op_i),
    .nbf_addr_i  (nbf_addr_i),
    .nbf_data_i  (nbf_data_i),
    .nbf_ready_o (nbf_ready_o),
    .done_o      (done_o),
    .bus_o       (ldr_bus)
  );

  mem_arbiter u_arbiter (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .ldr_i    (ldr_bus),
    .core_i   (core_bus),
    .dram_o   (dram_bus),
    .host_o   (host_bus)
  );

  dram_model u_dram (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .bus_i    (dram_bus)
  );

  host_regs u_host (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .bus_i      (host_bus),
    .finish_o   (finish_o),
    .trace_en_o (trace_en_o)
  );

endmodule

//--- tb/tb_mem_complex.sv
// Memory complex testbench
// LFSR-driven loader and core traffic checked against a memory and
// host register model that follows the observed handshakes

`timescale 1ns/1ps
`include "mem_consts.svh"

module tb_mem_complex;

  localparam int WAIT_LIMIT = 200;
  localparam int N_CONTEND  = 30;

  logic                   clk = 1'b0;
  logic                   arst_n;
  logic                   nbf_v;
  logic [`NBF_OP_W-1:0]   nbf_op;
  logic [`MEM_ADDR_W-1:0] nbf_addr;
  logic [`MEM_DATA_W-1:0] nbf_data;
  logic                   nbf_ready;
  logic                   done;
  logic                   core_v;
  logic                   core_we;
  logic [`MEM_ADDR_W-1:0] core_addr;
  logic [`MEM_DATA_W-1:0] core_wdata;
  logic                   core_ready;
  logic                   core_rsp_v;
  logic [`MEM_DATA_W-1:0] core_rsp_data;
  logic                   finish;
  logic [`TRACE_W-1:0]    trace_en;

  logic [31:0]            lfsr = 32'h495e_cab5;
  logic [`MEM_DATA_W-1:0] model_mem [`MEM_DEPTH];
  logic                   model_finish;
  logic                   model_done;
  logic [`TRACE_W-1:0]    model_trace;
  // Loader holds an accepted write that has not completed
  logic                   ldr_busy;
  logic                   last_core;
  logic [31:0]            exp_q [$];
  int                     cyc_q [$];
  int                     cyc;
  int                     n_checks;
  int                     n_mism;
  int                     n_other;
  logic [9:0]             ldr_word [N_CONTEND];
  logic [31:0]            ldr_data [N_CONTEND];
  logic [9:0]             core_word [N_CONTEND];
  logic                   core_we_s [N_CONTEND];
  logic [31:0]            core_data [N_CONTEND];

  mem_complex_top DUT (
    .clk_i           (clk),
    .arst_n_i        (arst_n),
    .nbf_v_i         (nbf_v),
    .nbf_op_i        (nbf_op),
    .nbf_addr_i      (nbf_addr),
    .nbf_data_i      (nbf_data),
    .nbf_ready_o     (nbf_ready),
    .done_o          (done),
    .core_v_i        (core_v),
    .core_we_i       (core_we),
    .core_addr_i     (core_addr),
    .core_wdata_i    (core_wdata),
    .core_ready_o    (core_ready),
    .core_rsp_v_o    (core_rsp_v),
    .core_rsp_data_o (core_rsp_data),
    .finish_o        (finish),
    .trace_en_o      (trace_en)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [15:0] dram_addr(input logic [9:0] word);
    return {1'b0, 5'b0, word};
  endfunction

  function automatic logic [15:0] dev_addr(input logic [6:0] did, input logic [1:0] idx);
    return {1'b1, did, 6'b0, idx};
  endfunction

  function automatic logic [31:0] model_read(input logic [15:0] addr);
    logic [31:0] v;
    v = '0;
    if (!addr[15])
      v = model_mem[addr[9:0]];
    else if (addr[14:8] == `HOST_DID && addr[1:0] == `HOST_REG_FINISH)
      v[0] = model_finish;
    else if (addr[14:8] == `HOST_DID && addr[1:0] == `HOST_REG_TRACE)
      v[`TRACE_W-1:0] = model_trace;
    return v;
  endfunction

  function automatic void model_write(input logic [15:0] addr, input logic [31:0] data);
    if (!addr[15])
      model_mem[addr[9:0]] = data;
    else if (addr[14:8] == `HOST_DID && addr[1:0] == `HOST_REG_FINISH)
      model_finish = 1'b1;
    else if (addr[14:8] == `HOST_DID && addr[1:0] == `HOST_REG_TRACE)
      model_trace = data[`TRACE_W-1:0];
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (act !== exp)
    begin
      n_mism++;
      $display("FAIL %s expected %h actual %h (cycle %0d)", name, exp, act, cyc);
    end
  endtask

  task automatic report_error(input string msg);
    n_other++;
    $display("ERROR at cycle %0d: %s", cyc, msg);
  endtask

  task automatic finish_run();
    $display("checks %0d, value mismatches %0d, other errors %0d", n_checks, n_mism, n_other);
    if (n_mism == 0 && n_other == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  endtask

  task automatic core_access(input logic we, input logic [15:0] addr, input logic [31:0] data);
    int waited;
    @(negedge clk);
    core_v     = 1'b1;
    core_we    = we;
    core_addr  = addr;
    core_wdata = data;
    waited     = 0;
    @(posedge clk);
    while (!core_ready && waited < WAIT_LIMIT)
    begin
      waited++;
      @(posedge clk);
    end
    if (waited >= WAIT_LIMIT)
    begin
      report_error("core request was never accepted");
      finish_run();
    end
    @(negedge clk);
    core_v = 1'b0;
  endtask

  task automatic nbf_send(input logic [1:0] op, input logic [15:0] addr, input logic [31:0] data);
    int waited;
    @(negedge clk);
    nbf_v    = 1'b1;
    nbf_op   = op;
    nbf_addr = addr;
    nbf_data = data;
    waited   = 0;
    @(posedge clk);
    while (!nbf_ready && waited < WAIT_LIMIT)
    begin
      waited++;
      @(posedge clk);
    end
    if (waited >= WAIT_LIMIT)
    begin
      report_error("loader command was never accepted");
      finish_run();
    end
    @(negedge clk);
    nbf_v = 1'b0;
  endtask

  task automatic wait_core_idle();
    int waited;
    waited = 0;
    @(negedge clk);
    while (exp_q.size() != 0 && waited < WAIT_LIMIT)
    begin
      waited++;
      @(negedge clk);
    end
    if (waited >= WAIT_LIMIT)
    begin
      report_error("core responses still missing");
      finish_run();
    end
  endtask

  task automatic wait_loader_idle();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!nbf_ready && waited < WAIT_LIMIT)
    begin
      waited++;
      @(negedge clk);
    end
    if (waited >= WAIT_LIMIT)
    begin
      report_error("loader did not return to idle");
      finish_run();
    end
  endtask

  // Model update and response checks at each rising edge
  always @(posedge clk)
  begin
    if (arst_n)
    begin
      cyc++;
      check_val("done_o", model_done, done);
      check_val("finish_o", model_finish, finish);
      check_val("trace_en_o", model_trace, trace_en);
      if (model_done && nbf_ready)
        report_error("loader became ready after the finish command");
      if (core_rsp_v && exp_q.size() == 0)
        report_error("core response without a pending request");
      else if (core_rsp_v)
      begin
        check_val("core_rsp_data_o", exp_q.pop_front(), core_rsp_data);
        check_val("core_rsp_v_o latency", 1, cyc - cyc_q.pop_front());
      end
      // Loader write completed and held the bus last
      if (ldr_busy && nbf_ready)
      begin
        ldr_busy  = 1'b0;
        last_core = 1'b0;
      end
      if (core_v && core_ready)
      begin
        if (ldr_busy && last_core)
          report_error("core won arbitration twice while the loader was waiting");
        last_core = 1'b1;
        exp_q.push_back(core_we ? 32'h0 : model_read(core_addr));
        cyc_q.push_back(cyc);
        if (core_we)
          model_write(core_addr, core_wdata);
      end
      if (nbf_v && nbf_ready && nbf_op == `NBF_OP_WRITE)
      begin
        model_write(nbf_addr, nbf_data);
        ldr_busy = 1'b1;
      end
      if (nbf_v && nbf_ready && nbf_op == `NBF_OP_FINISH)
        model_done = 1'b1;
    end
  end

  initial
  begin
    int          i;
    int          j;
    int          k;
    logic [9:0]  w;
    logic [9:0]  last_w;
    logic [31:0] d;
    logic        we;
    logic [6:0]  did;
    logic [9:0]  wr_q [$];
    arst_n = 1'b0;
    nbf_v = 1'b0;
    nbf_op = '0;
    nbf_addr = '0;
    nbf_data = '0;
    core_v = 1'b0;
    core_we = 1'b0;
    core_addr = '0;
    core_wdata = '0;
    model_finish = 1'b0;
    model_done = 1'b0;
    model_trace = '0;
    ldr_busy = 1'b0;
    last_core = 1'b0;
    cyc = 0;
    n_checks = 0;
    n_mism = 0;
    n_other = 0;
    for (i = 0; i < `MEM_DEPTH; i++)
      model_mem[i] = '0;

    repeat (8) @(posedge clk);
    @(negedge clk);
    check_val("core_ready_o", 0, core_ready);
    check_val("nbf_ready_o", 0, nbf_ready);
    check_val("core_rsp_v_o", 0, core_rsp_v);
    check_val("done_o", 0, done);
    check_val("finish_o", 0, finish);
    check_val("trace_en_o", 0, trace_en);
    arst_n = 1'b1;
    @(posedge clk);
    @(negedge clk);
    check_val("nbf_ready_o", 1, nbf_ready);
    check_val("core_ready_o", 1, core_ready);

    // Memory reads zero after reset
    for (i = 0; i < 16; i++)
      core_access(1'b0, dram_addr(rand_bits(10)), 32'h0);
    wait_core_idle();

    // Loader writes and ignored opcodes followed by core read-back
    for (i = 0; i < 24; i++)
    begin
      w = rand_bits(10);
      d = rand_bits(32);
      wr_q.push_back(w);
      nbf_send(`NBF_OP_WRITE, dram_addr(w), d);
      if (i % 8 == 7)
        nbf_send((i % 16 == 7) ? 2'd0 : 2'd3, dram_addr(w), ~d);
    end
    wait_loader_idle();
    for (i = 0; i < wr_q.size(); i++)
      core_access(1'b0, dram_addr(wr_q[i]), 32'h0);
    wait_core_idle();

    // Core traffic with gaps and read-after-write
    last_w = rand_bits(10);
    for (i = 0; i < 60; i++)
    begin
      we = rand_bits(1);
      w = rand_bits(1) ? last_w : rand_bits(10);
      d = rand_bits(32);
      core_access(we, dram_addr(w), d);
      if (we)
        last_w = w;
      repeat (rand_bits(2)) @(negedge clk);
    end
    wait_core_idle();

    // Contention with the loader in the upper half and the core below
    for (i = 0; i < N_CONTEND; i++)
    begin
      ldr_word[i] = 10'h200 | rand_bits(9);
      ldr_data[i] = rand_bits(32);
      core_word[i] = rand_bits(9);
      core_we_s[i] = rand_bits(1);
      core_data[i] = rand_bits(32);
    end
    fork
      for (j = 0; j < N_CONTEND; j++)
        nbf_send(`NBF_OP_WRITE, dram_addr(ldr_word[j]), ldr_data[j]);
      for (k = 0; k < N_CONTEND; k++)
        core_access(core_we_s[k], dram_addr(core_word[k]), core_data[k]);
    join
    wait_loader_idle();
    wait_core_idle();
    for (i = 0; i < N_CONTEND; i++)
    begin
      core_access(1'b0, dram_addr(ldr_word[i]), 32'h0);
      core_access(1'b0, dram_addr(core_word[i]), 32'h0);
    end
    wait_core_idle();

    // Host registers
    d = rand_bits(32);
    core_access(1'b1, dev_addr(`HOST_DID, `HOST_REG_TRACE), d);
    wait_core_idle();
    check_val("trace_en_o", d[`TRACE_W-1:0], trace_en);
    core_access(1'b0, dev_addr(`HOST_DID, `HOST_REG_TRACE), 32'h0);
    core_access(1'b1, dev_addr(7'h12, `HOST_REG_TRACE), ~d);
    core_access(1'b1, dev_addr(`HOST_DID, `HOST_REG_FINISH), rand_bits(32));
    wait_core_idle();
    check_val("finish_o", 1, finish);
    core_access(1'b0, dev_addr(`HOST_DID, `HOST_REG_FINISH), 32'h0);
    core_access(1'b0, dev_addr(`HOST_DID, 2'd3), 32'h0);
    for (i = 0; i < 6; i++)
    begin
      did = rand_bits(7);
      if (did == `HOST_DID)
        did = 7'h01;
      core_access(1'b0, dev_addr(did, rand_bits(2)), 32'h0);
    end
    wait_core_idle();

    // Loader finish while the core keeps working
    nbf_send(`NBF_OP_FINISH, 16'h0, 32'h0);
    @(negedge clk);
    nbf_v = 1'b1;
    nbf_op = `NBF_OP_WRITE;
    repeat (6) @(negedge clk);
    nbf_v = 1'b0;
    for (i = 0; i < 10; i++)
    begin
      we = rand_bits(1);
      w = rand_bits(10);
      d = rand_bits(32);
      core_access(we, dram_addr(w), d);
    end
    wait_core_idle();
    check_val("done_o", 1, done);
    check_val("nbf_ready_o", 0, nbf_ready);
    finish_run();
  end

endmodule

//--- mem_complex_top.f
+incdir+logic
logic/mem_pkg.sv
logic/mem_bus_if.sv
logic/mem_arbiter.sv
logic/dram_model.sv
logic/host_regs.sv
logic/nbf_loader.sv
logic/mem_complex_top.sv
tb/tb_mem_complex.sv
